//--- dv/pipe_checks.svh
/*
 * Compare tasks for the pipeline back-end testbench.
 * Included inside the testbench module body, after the package import.
 * Each one sets ok when the actual result matches the expected one.
 */
`ifndef PIPE_CHECKS_SVH
`define PIPE_CHECKS_SVH

// Commit port result, destination register and written value
task automatic check_commit(
    input  string                 name,
    input  logic [REG_ADDR_W-1:0] exp_rd,
    input  logic [DATA_W-1:0]     exp_data,
    input  logic [REG_ADDR_W-1:0] act_rd,
    input  logic [DATA_W-1:0]     act_data,
    output bit                    ok
);
    ok = (act_rd === exp_rd) && (act_data === exp_data);
    if (!ok) begin
        $display("** Error %s: expected rd %0d data %h, actual rd %0d data %h",
                 name, exp_rd, exp_data, act_rd, act_data);
    end
endtask

// Wishbone write, byte address and store data
task automatic check_store(
    input  string             name,
    input  logic [DATA_W-1:0] exp_adr,
    input  logic [DATA_W-1:0] exp_dat,
    input  logic [DATA_W-1:0] act_adr,
    input  logic [DATA_W-1:0] act_dat,
    output bit                ok
);
    ok = (act_adr === exp_adr) && (act_dat === exp_dat);
    if (!ok) begin
        $display("** Error %s: expected adr %h data %h, actual adr %h data %h",
                 name, exp_adr, exp_dat, act_adr, act_dat);
    end
endtask

`endif

//--- dv/pipe_backend_tb.sv
/*
 * Testbench for the pipeline back end.
 * Reads instructions and expected results from the vector file, issues them
 * in order, serves loads and stores from a small Wishbone memory with random
 * wait states and checks every commit and bus write in program order.
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_backend_tb;
    import pipe_pkg::*;

    localparam int DATA_W   = 32;
    localparam int NUM_VEC  = 16;
    localparam int TIMEOUT  = 200;
    localparam logic [31:0] SEED = 32'h8759;

    `include "pipe_checks.svh"

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  instr_valid_i;
    logic                  instr_ready_o;
    op_e                   op_i;
    logic [REG_ADDR_W-1:0] rd_i;
    logic [REG_ADDR_W-1:0] rs1_i;
    logic [REG_ADDR_W-1:0] rs2_i;
    logic [DATA_W-1:0]     imm_i;
    logic                  wrb_valid_o;
    logic [REG_ADDR_W-1:0] wrb_rd_o;
    logic [DATA_W-1:0]     wrb_data_o;
    logic                  wb_cyc_o;
    logic                  wb_stb_o;
    logic                  wb_we_o;
    logic [DATA_W-1:0]     wb_adr_o;
    logic [DATA_W-1:0]     wb_dat_o;
    logic [DATA_W-1:0]     wb_dat_i;
    logic                  wb_ack_i;

    // Six hex words per vector: op rd rs1 rs2 imm expected
    logic [31:0]           vec_mem [0:6*NUM_VEC-1];
    op_e                   v_op    [0:NUM_VEC-1];
    logic [REG_ADDR_W-1:0] v_rd    [0:NUM_VEC-1];
    logic [REG_ADDR_W-1:0] v_rs1   [0:NUM_VEC-1];
    logic [REG_ADDR_W-1:0] v_rs2   [0:NUM_VEC-1];
    logic [DATA_W-1:0]     v_imm   [0:NUM_VEC-1];
    logic [DATA_W-1:0]     v_exp   [0:NUM_VEC-1];
    logic [DATA_W-1:0]     v_addr  [0:NUM_VEC-1];

    // Wishbone memory model state
    logic [DATA_W-1:0]     mem [0:63];
    logic [31:0]           rng_state = SEED;
    logic [1:0]            wait_left = 2'd0;

    int next_chk   = 0;
    int pass_count = 0;
    int fail_count = 0;
    int extra_errs = 0;
    bit timed_out  = 1'b0;

    pipe_backend_top #(.DATA_W(DATA_W)) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .op_i          (op_i),
        .rd_i          (rd_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .imm_i         (imm_i),
        .wrb_valid_o   (wrb_valid_o),
        .wrb_rd_o      (wrb_rd_o),
        .wrb_data_o    (wrb_data_o),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_o      (wb_dat_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string test_name(input int idx);
        op_e op;
        op = v_op[idx];
        return $sformatf("vec%0d %s", idx, op.name());
    endfunction

    // Unpacks the vectors and works out store addresses from a shadow register file
    task automatic build_expected();
        logic [DATA_W-1:0] shadow [0:2**REG_ADDR_W-1];
        int i;
        for (i = 0; i < 2**REG_ADDR_W; i++) begin
            shadow[i] = '0;
        end
        for (i = 0; i < NUM_VEC; i++) begin
            v_op[i]  = op_e'(vec_mem[6*i][2:0]);
            v_rd[i]  = vec_mem[6*i+1][REG_ADDR_W-1:0];
            v_rs1[i] = vec_mem[6*i+2][REG_ADDR_W-1:0];
            v_rs2[i] = vec_mem[6*i+3][REG_ADDR_W-1:0];
            v_imm[i] = vec_mem[6*i+4][DATA_W-1:0];
            v_exp[i] = vec_mem[6*i+5][DATA_W-1:0];
            // Byte address is rs1 + imm
            v_addr[i] = shadow[v_rs1[i]] + v_imm[i];
            if ((v_op[i] != OP_SW) && (v_rd[i] != '0)) begin
                shadow[v_rd[i]] = v_exp[i];
            end
        end
    endtask

    task automatic finish_test(input int idx, input bit ok);
        if (ok) begin
            $display("%s: PASS", test_name(idx));
            pass_count++;
        end else begin
            $display("%s: FAIL", test_name(idx));
            fail_count++;
        end
        next_chk++;
    endtask

    task automatic handle_commit(input logic [REG_ADDR_W-1:0] act_rd,
                                 input logic [DATA_W-1:0] act_data);
        bit ok;
        if (next_chk >= NUM_VEC) begin
            $display("A commit of rd %0d arrived after the last vector", act_rd);
            extra_errs++;
        end else if (v_op[next_chk] == OP_SW) begin
            $display("%s should write the bus but a commit of rd %0d arrived",
                     test_name(next_chk), act_rd);
            finish_test(next_chk, 1'b0);
        end else begin
            check_commit(test_name(next_chk), v_rd[next_chk], v_exp[next_chk],
                         act_rd, act_data, ok);
            finish_test(next_chk, ok);
        end
    endtask

    task automatic record_store(input logic [DATA_W-1:0] act_adr,
                                input logic [DATA_W-1:0] act_dat);
        bit ok;
        if (next_chk >= NUM_VEC) begin
            $display("A bus write to %h arrived after the last vector", act_adr);
            extra_errs++;
        end else if (v_op[next_chk] != OP_SW) begin
            $display("%s should commit but a bus write to %h arrived",
                     test_name(next_chk), act_adr);
            finish_test(next_chk, 1'b0);
        end else begin
            check_store(test_name(next_chk), v_addr[next_chk], v_exp[next_chk],
                        act_adr, act_dat, ok);
            finish_test(next_chk, ok);
        end
    endtask

    // Wishbone slave, 0 to 3 wait states per access, ack held for one cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack_i  <= 1'b0;
            wait_left <= 2'd0;
            rng_state <= SEED;
        end else if (wb_ack_i) begin
            wb_ack_i  <= 1'b0;
            wait_left <= rng_state[1:0];
            rng_state <= xorshift(rng_state);
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                wb_ack_i <= 1'b1;
                if (wb_we_o) begin
                    mem[wb_adr_o[7:2]] <= wb_dat_o;
                end else begin
                    wb_dat_i <= mem[wb_adr_o[7:2]];
                end
            end
        end
    end

    // Scoreboard, the WRB commit is always older than the access in LSU
    always @(posedge clk) begin
        if (rst_n) begin
            if (wrb_valid_o) begin
                handle_commit(wrb_rd_o, wrb_data_o);
            end
            if (wb_cyc_o && wb_stb_o && wb_we_o && wb_ack_i) begin
                record_store(wb_adr_o, wb_dat_o);
            end
        end
    end

    initial begin
        int vi;
        int waited;
        int i;
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        op_i          = OP_ADD;
        rd_i          = '0;
        rs1_i         = '0;
        rs2_i         = '0;
        imm_i         = '0;
        wb_dat_i      = '0;
        wb_ack_i      = 1'b0;
        for (i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
        $readmemh("dv/pipe_vectors.txt", vec_mem);
        build_expected();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Next instruction goes out on the edge that accepts the previous one
        for (vi = 0; (vi < NUM_VEC) && !timed_out; vi++) begin
            instr_valid_i <= 1'b1;
            op_i          <= v_op[vi];
            rd_i          <= v_rd[vi];
            rs1_i         <= v_rs1[vi];
            rs2_i         <= v_rs2[vi];
            imm_i         <= v_imm[vi];
            waited = 0;
            @(posedge clk);
            while (!instr_ready_o && !timed_out) begin
                waited++;
                if (waited >= TIMEOUT) begin
                    $display("Timeout: vec%0d was not accepted within %0d cycles", vi, TIMEOUT);
                    timed_out = 1'b1;
                end else begin
                    @(posedge clk);
                end
            end
        end
        instr_valid_i <= 1'b0;

        // Drain until every vector has been checked
        waited = 0;
        while ((next_chk < NUM_VEC) && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited >= TIMEOUT) begin
                $display("Timeout: only %0d of %0d vectors finished", next_chk, NUM_VEC);
                timed_out = 1'b1;
            end
        end
        // A few idle cycles to catch a duplicated commit
        repeat (6) @(posedge clk);

        $display("%0d vectors: %0d passed, %0d failed, %0d other errors",
                 NUM_VEC, pass_count, fail_count, extra_errs);
        if (!timed_out && (fail_count == 0) && (extra_errs == 0) && (pass_count == NUM_VEC)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : pipe_backend_tb

`default_nettype wire

//--- dv/pipe_vectors.txt
// op rd rs1 rs2 imm expected, all hex; op 0 ADD 1 SUB 2 AND 3 XOR 4 ADDI 5 LW 6 SW
// expected is the commit data, or the bus write data for SW
4 01 00 00 00000015 00000015
4 02 01 00 0000000a 0000001f
0 03 01 02 00000000 00000034
1 04 03 01 00000000 0000001f
2 05 04 03 00000000 00000014
3 06 05 02 00000000 0000000b
4 07 00 00 00000040 00000040
6 00 07 06 00000008 0000000b
5 08 07 00 00000008 0000000b
0 09 08 03 00000000 0000003f
4 00 09 00 00000100 00000000
0 0a 00 09 00000000 0000003f
1 0b 0a 01 00000000 0000002a
6 00 07 0b 0000000c 0000002a
5 0c 07 00 0000000c 0000002a
3 0d 0c 06 00000000 00000021

//--- project.f
+incdir+dv
verilog/pipe_pkg.sv
verilog/id_stage.sv
verilog/exe_stage.sv
verilog/lsu_stage.sv
verilog/forward_stall.sv
verilog/pipe_backend_top.sv
dv/pipe_backend_tb.sv

//--- verilog/exe_stage.sv
/*
 * Execute stage of the back end.
 * Picks each operand from LSU, WRB or the register file value, runs the ALU
 * (or the address add for loads and stores) and fills the EXE-to-LSU register.
 */
`timescale 1ns/10ps
`default_nettype none

module exe_stage #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Instruction in EXE
    input  logic                            exe_valid_i,
    input  pipe_pkg::op_e                   exe_op_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] exe_rd_i,
    input  logic [DATA_W-1:0]               exe_imm_i,
    input  logic [DATA_W-1:0]               exe_a_i,
    input  logic [DATA_W-1:0]               exe_b_i,
    // Forward selects and WRB value
    input  logic                            fwd_lsu_rs1_i,
    input  logic                            fwd_lsu_rs2_i,
    input  logic                            fwd_wrb_rs1_i,
    input  logic                            fwd_wrb_rs2_i,
    input  logic [DATA_W-1:0]               wrb_data_i,
    // Pipeline control
    input  logic                            stall_i,
    input  logic                            flush_i,
    input  logic                            lsu_stall_i,
    // Instruction in LSU
    output logic                            lsu_valid_o,
    output pipe_pkg::op_e                   lsu_op_o,
    output logic [pipe_pkg::REG_ADDR_W-1:0] lsu_rd_o,
    output logic                            lsu_wr_req_o,
    output logic [DATA_W-1:0]               lsu_result_o,
    output logic [DATA_W-1:0]               lsu_store_data_o
);
    import pipe_pkg::*;

    logic [DATA_W-1:0] opnd_a;
    logic [DATA_W-1:0] opnd_b;
    logic [DATA_W-1:0] alu_res;

    // LSU is the younger producer, so it wins over WRB
    assign opnd_a = fwd_lsu_rs1_i ? lsu_result_o :
                    fwd_wrb_rs1_i ? wrb_data_i : exe_a_i;
    assign opnd_b = fwd_lsu_rs2_i ? lsu_result_o :
                    fwd_wrb_rs2_i ? wrb_data_i : exe_b_i;

    always_comb begin
        case (exe_op_i)
            OP_ADD:  alu_res = opnd_a + opnd_b;
            OP_SUB:  alu_res = opnd_a - opnd_b;
            OP_AND:  alu_res = opnd_a & opnd_b;
            OP_XOR:  alu_res = opnd_a ^ opnd_b;
            // ADDI and the byte address of LW/SW
            default: alu_res = opnd_a + exe_imm_i;
        endcase
    end

    // Control bits, a held LSU keeps its instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu_valid_o  <= 1'b0;
            lsu_wr_req_o <= 1'b0;
        end else if (!lsu_stall_i) begin
            if (flush_i || stall_i) begin
                lsu_valid_o  <= 1'b0;
                lsu_wr_req_o <= 1'b0;
            end else begin
                lsu_valid_o  <= exe_valid_i;
                lsu_wr_req_o <= exe_valid_i && (exe_op_i != OP_SW) && (exe_rd_i != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!lsu_stall_i) begin
            lsu_op_o         <= exe_op_i;
            lsu_rd_o         <= exe_rd_i;
            lsu_result_o     <= alu_res;
            // Store data is rs2 after forwarding
            lsu_store_data_o <= opnd_b;
        end
    end

endmodule : exe_stage

`default_nettype wire

//--- verilog/forward_stall.sv
/*
 * Forwarding and stall controller.
 * Compares the EXE sources with the LSU and WRB destinations, picks the
 * forward paths, inserts the load-use bubble and holds the pipe while a
 * bus access waits for its ack.
 */
`timescale 1ns/10ps
`default_nettype none

module forward_stall (
    input  logic                            clk,
    input  logic                            rst_n,
    // Instruction in EXE
    input  logic                            exe_valid_i,
    input  pipe_pkg::op_e                   exe_op_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] exe_rs1_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] exe_rs2_i,
    // Instruction in LSU
    input  logic                            lsu_valid_i,
    input  pipe_pkg::op_e                   lsu_op_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] lsu_rd_i,
    input  logic                            lsu_wr_req_i,
    input  logic                            lsu_req_i,
    input  logic                            lsu_ack_i,
    // Instruction in WRB
    input  logic [pipe_pkg::REG_ADDR_W-1:0] wrb_rd_i,
    input  logic                            wrb_wr_req_i,
    // Forward selects and pipeline control
    output logic                            fwd_lsu_rs1_o,
    output logic                            fwd_lsu_rs2_o,
    output logic                            fwd_wrb_rs1_o,
    output logic                            fwd_wrb_rs2_o,
    output logic                            if_id_exe_stall_o,
    output logic                            exe2lsu_flush_o,
    output logic                            lsu_stall_o
);
    import pipe_pkg::*;

    logic use_rs1;
    logic use_rs2;
    logic lsu_hit_rs1;
    logic lsu_hit_rs2;
    logic lsu_load;
    logic ld_use;
    logic lsu_stall_q;
    logic lsu_stall_d;

    // Every opcode reads rs1, only register ops and stores read rs2
    assign use_rs1 = exe_valid_i && (exe_rs1_i != '0);
    assign use_rs2 = exe_valid_i && (exe_rs2_i != '0) && (exe_op_i inside {
                         OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SW});

    assign lsu_hit_rs1 = use_rs1 && lsu_wr_req_i && (lsu_rd_i == exe_rs1_i);
    assign lsu_hit_rs2 = use_rs2 && lsu_wr_req_i && (lsu_rd_i == exe_rs2_i);
    assign lsu_load    = lsu_valid_i && (lsu_op_i == OP_LW);

    // A load result is not ready in LSU, it comes from WRB a cycle later
    assign fwd_lsu_rs1_o = lsu_hit_rs1 && !lsu_load;
    assign fwd_lsu_rs2_o = lsu_hit_rs2 && !lsu_load;
    assign fwd_wrb_rs1_o = use_rs1 && wrb_wr_req_i && (wrb_rd_i == exe_rs1_i);
    assign fwd_wrb_rs2_o = use_rs2 && wrb_wr_req_i && (wrb_rd_i == exe_rs2_i);

    // Bubble only once the load has its data, the bus wait covers the rest
    assign ld_use = (lsu_hit_rs1 || lsu_hit_rs2) && lsu_load && !lsu_stall_d;

    // Bus wait, set on request and cleared on ack
    always_comb begin
        lsu_stall_d = lsu_stall_q;
        if (lsu_ack_i) begin
            lsu_stall_d = 1'b0;
        end else if (lsu_req_i) begin
            lsu_stall_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu_stall_q <= 1'b0;
        end else begin
            lsu_stall_q <= lsu_stall_d;
        end
    end

    assign lsu_stall_o       = lsu_stall_d;
    assign if_id_exe_stall_o = ld_use || lsu_stall_d;
    assign exe2lsu_flush_o   = ld_use;

endmodule : forward_stall

`default_nettype wire

//--- verilog/id_stage.sv
/*
 * Decode stage of the back end.
 * Latches accepted instructions from the issue port, reads the register file
 * with write-through from WRB and fills the ID-to-EXE pipeline register.
 * Everything holds while the controller stalls the front stages.
 */
`timescale 1ns/10ps
`default_nettype none

module id_stage #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Issue port
    input  logic                            instr_valid_i,
    output logic                            instr_ready_o,
    input  pipe_pkg::op_e                   op_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [DATA_W-1:0]               imm_i,
    // Front stall from the controller
    input  logic                            stall_i,
    // Write port from WRB
    input  logic                            wrb_wr_req_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] wrb_rd_i,
    input  logic [DATA_W-1:0]               wrb_data_i,
    // Instruction in EXE
    output logic                            exe_valid_o,
    output pipe_pkg::op_e                   exe_op_o,
    output logic [pipe_pkg::REG_ADDR_W-1:0] exe_rd_o,
    output logic [pipe_pkg::REG_ADDR_W-1:0] exe_rs1_o,
    output logic [pipe_pkg::REG_ADDR_W-1:0] exe_rs2_o,
    output logic [DATA_W-1:0]               exe_imm_o,
    output logic [DATA_W-1:0]               exe_a_o,
    output logic [DATA_W-1:0]               exe_b_o
);
    import pipe_pkg::*;

    logic [DATA_W-1:0]     regs [0:2**REG_ADDR_W-1];
    // Instruction sitting in ID
    logic                  id_valid_q;
    op_e                   id_op_q;
    logic [REG_ADDR_W-1:0] id_rd_q;
    logic [REG_ADDR_W-1:0] id_rs1_q;
    logic [REG_ADDR_W-1:0] id_rs2_q;
    logic [DATA_W-1:0]     id_imm_q;
    logic [DATA_W-1:0]     rd_a;
    logic [DATA_W-1:0]     rd_b;
    logic                  exe_hit_a;
    logic                  exe_hit_b;

    // Nothing is taken while the front is held
    assign instr_ready_o = ~stall_i;

    // Register file write, x0 is never written
    always_ff @(posedge clk) begin
        if (wrb_wr_req_i && (wrb_rd_i != '0)) begin
            regs[wrb_rd_i] <= wrb_data_i;
        end
    end

    // Read ports, a same-cycle WRB write passes straight through
    assign rd_a = (id_rs1_q == '0) ? '0 :
                  (wrb_wr_req_i && (wrb_rd_i == id_rs1_q)) ? wrb_data_i : regs[id_rs1_q];
    assign rd_b = (id_rs2_q == '0) ? '0 :
                  (wrb_wr_req_i && (wrb_rd_i == id_rs2_q)) ? wrb_data_i : regs[id_rs2_q];

    // A held EXE instruction keeps picking up WRB writes so no result slips past it
    assign exe_hit_a = wrb_wr_req_i && (exe_rs1_o != '0) && (wrb_rd_i == exe_rs1_o);
    assign exe_hit_b = wrb_wr_req_i && (exe_rs2_o != '0) && (wrb_rd_i == exe_rs2_o);

    // Valid bits, a bubble goes in whenever nothing is accepted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid_q  <= 1'b0;
            exe_valid_o <= 1'b0;
        end else if (!stall_i) begin
            id_valid_q  <= instr_valid_i;
            exe_valid_o <= id_valid_q;
        end
    end

    // Payload of ID and ID-to-EXE
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_op_q   <= op_i;
            id_rd_q   <= rd_i;
            id_rs1_q  <= rs1_i;
            id_rs2_q  <= rs2_i;
            id_imm_q  <= imm_i;
            exe_op_o  <= id_op_q;
            exe_rd_o  <= id_rd_q;
            exe_rs1_o <= id_rs1_q;
            exe_rs2_o <= id_rs2_q;
            exe_imm_o <= id_imm_q;
            exe_a_o   <= rd_a;
            exe_b_o   <= rd_b;
        end else begin
            if (exe_hit_a) begin
                exe_a_o <= wrb_data_i;
            end
            if (exe_hit_b) begin
                exe_b_o <= wrb_data_i;
            end
        end
    end

endmodule : id_stage

`default_nettype wire

//--- verilog/lsu_stage.sv
/*
 * Memory stage of the back end.
 * Runs a Wishbone classic master for LW and SW and fills the LSU-to-WRB
 * register with the ALU result or the loaded word. The WRB register drives
 * the commit port and the register file write.
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_stage #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Instruction in LSU
    input  logic                            lsu_valid_i,
    input  pipe_pkg::op_e                   lsu_op_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] lsu_rd_i,
    input  logic                            lsu_wr_req_i,
    input  logic [DATA_W-1:0]               lsu_result_i,
    input  logic [DATA_W-1:0]               lsu_store_data_i,
    input  logic                            lsu_stall_i,
    // Wishbone classic master
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic                            wb_we_o,
    output logic [DATA_W-1:0]               wb_adr_o,
    output logic [DATA_W-1:0]               wb_dat_o,
    input  logic [DATA_W-1:0]               wb_dat_i,
    input  logic                            wb_ack_i,
    // Bus status to the controller
    output logic                            lsu_req_o,
    output logic                            lsu_ack_o,
    // WRB stage and commit port
    output logic                            wrb_valid_o,
    output logic [pipe_pkg::REG_ADDR_W-1:0] wrb_rd_o,
    output logic                            wrb_wr_req_o,
    output logic [DATA_W-1:0]               wrb_data_o
);
    import pipe_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } lsu_state_e;

    lsu_state_e state_q;
    logic       mem_op;
    logic       bus_act;

    assign mem_op  = lsu_valid_i && ((lsu_op_i == OP_LW) || (lsu_op_i == OP_SW));
    // One idle cycle after each ack, so back-to-back accesses drop cyc in between
    assign bus_act = mem_op && (state_q != DONE);

    assign wb_cyc_o = bus_act;
    assign wb_stb_o = bus_act;
    assign wb_we_o  = (lsu_op_i == OP_SW);
    assign wb_adr_o = lsu_result_i;
    assign wb_dat_o = lsu_store_data_i;

    // Pending until acked, this also covers a new access waiting out DONE
    assign lsu_req_o = mem_op;
    assign lsu_ack_o = bus_act && wb_ack_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (bus_act) begin
                        state_q <= wb_ack_i ? DONE : BUS;
                    end
                end
                BUS: begin
                    if (wb_ack_i) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // WRB takes a bubble while the bus access is outstanding
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrb_valid_o  <= 1'b0;
            wrb_wr_req_o <= 1'b0;
        end else begin
            wrb_valid_o  <= lsu_valid_i && !lsu_stall_i && (lsu_op_i != OP_SW);
            wrb_wr_req_o <= lsu_wr_req_i && !lsu_stall_i;
        end
    end

    // Read data is captured on the ack edge; x0 results commit as zero
    always_ff @(posedge clk) begin
        if (!lsu_stall_i) begin
            wrb_rd_o   <= lsu_rd_i;
            wrb_data_o <= (lsu_rd_i == '0) ? '0 :
                          (lsu_op_i == OP_LW) ? wb_dat_i : lsu_result_i;
        end
    end

endmodule : lsu_stage

`default_nettype wire

//--- verilog/pipe_backend_top.sv
/*
 * Top level of the pipeline back end.
 * Wires the ID, EXE and LSU/WRB stages to the forwarding and stall
 * controller and brings out the issue, commit and Wishbone ports.
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_backend_top #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Issue port
    input  logic                            instr_valid_i,
    output logic                            instr_ready_o,
    input  pipe_pkg::op_e                   op_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [pipe_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [DATA_W-1:0]               imm_i,
    // Commit port
    output logic                            wrb_valid_o,
    output logic [pipe_pkg::REG_ADDR_W-1:0] wrb_rd_o,
    output logic [DATA_W-1:0]               wrb_data_o,
    // Wishbone classic data bus
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic                            wb_we_o,
    output logic [DATA_W-1:0]               wb_adr_o,
    output logic [DATA_W-1:0]               wb_dat_o,
    input  logic [DATA_W-1:0]               wb_dat_i,
    input  logic                            wb_ack_i
);
    import pipe_pkg::*;

    // ID to EXE
    logic                  exe_valid;
    op_e                   exe_op;
    logic [REG_ADDR_W-1:0] exe_rd;
    logic [REG_ADDR_W-1:0] exe_rs1;
    logic [REG_ADDR_W-1:0] exe_rs2;
    logic [DATA_W-1:0]     exe_imm;
    logic [DATA_W-1:0]     exe_a;
    logic [DATA_W-1:0]     exe_b;
    // EXE to LSU
    logic                  lsu_valid;
    op_e                   lsu_op;
    logic [REG_ADDR_W-1:0] lsu_rd;
    logic                  lsu_wr_req;
    logic [DATA_W-1:0]     lsu_result;
    logic [DATA_W-1:0]     lsu_store_data;
    logic                  lsu_req;
    logic                  lsu_ack;
    logic                  wrb_wr_req;
    // Controller outputs
    logic                  fwd_lsu_rs1;
    logic                  fwd_lsu_rs2;
    logic                  fwd_wrb_rs1;
    logic                  fwd_wrb_rs2;
    logic                  if_id_exe_stall;
    logic                  exe2lsu_flush;
    logic                  lsu_stall;

    id_stage #(.DATA_W(DATA_W)) u_id (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .op_i          (op_i),
        .rd_i          (rd_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .imm_i         (imm_i),
        .stall_i       (if_id_exe_stall),
        .wrb_wr_req_i  (wrb_wr_req),
        .wrb_rd_i      (wrb_rd_o),
        .wrb_data_i    (wrb_data_o),
        .exe_valid_o   (exe_valid),
        .exe_op_o      (exe_op),
        .exe_rd_o      (exe_rd),
        .exe_rs1_o     (exe_rs1),
        .exe_rs2_o     (exe_rs2),
        .exe_imm_o     (exe_imm),
        .exe_a_o       (exe_a),
        .exe_b_o       (exe_b)
    );

    exe_stage #(.DATA_W(DATA_W)) u_exe (
        .clk              (clk),
        .rst_n            (rst_n),
        .exe_valid_i      (exe_valid),
        .exe_op_i         (exe_op),
        .exe_rd_i         (exe_rd),
        .exe_imm_i        (exe_imm),
        .exe_a_i          (exe_a),
        .exe_b_i          (exe_b),
        .fwd_lsu_rs1_i    (fwd_lsu_rs1),
        .fwd_lsu_rs2_i    (fwd_lsu_rs2),
        .fwd_wrb_rs1_i    (fwd_wrb_rs1),
        .fwd_wrb_rs2_i    (fwd_wrb_rs2),
        .wrb_data_i       (wrb_data_o),
        .stall_i          (if_id_exe_stall),
        .flush_i          (exe2lsu_flush),
        .lsu_stall_i      (lsu_stall),
        .lsu_valid_o      (lsu_valid),
        .lsu_op_o         (lsu_op),
        .lsu_rd_o         (lsu_rd),
        .lsu_wr_req_o     (lsu_wr_req),
        .lsu_result_o     (lsu_result),
        .lsu_store_data_o (lsu_store_data)
    );

    lsu_stage #(.DATA_W(DATA_W)) u_lsu (
        .clk              (clk),
        .rst_n            (rst_n),
        .lsu_valid_i      (lsu_valid),
        .lsu_op_i         (lsu_op),
        .lsu_rd_i         (lsu_rd),
        .lsu_wr_req_i     (lsu_wr_req),
        .lsu_result_i     (lsu_result),
        .lsu_store_data_i (lsu_store_data),
        .lsu_stall_i      (lsu_stall),
        .wb_cyc_o         (wb_cyc_o),
        .wb_stb_o         (wb_stb_o),
        .wb_we_o          (wb_we_o),
        .wb_adr_o         (wb_adr_o),
        .wb_dat_o         (wb_dat_o),
        .wb_dat_i         (wb_dat_i),
        .wb_ack_i         (wb_ack_i),
        .lsu_req_o        (lsu_req),
        .lsu_ack_o        (lsu_ack),
        .wrb_valid_o      (wrb_valid_o),
        .wrb_rd_o         (wrb_rd_o),
        .wrb_wr_req_o     (wrb_wr_req),
        .wrb_data_o       (wrb_data_o)
    );

    forward_stall u_fwd (
        .clk               (clk),
        .rst_n             (rst_n),
        .exe_valid_i       (exe_valid),
        .exe_op_i          (exe_op),
        .exe_rs1_i         (exe_rs1),
        .exe_rs2_i         (exe_rs2),
        .lsu_valid_i       (lsu_valid),
        .lsu_op_i          (lsu_op),
        .lsu_rd_i          (lsu_rd),
        .lsu_wr_req_i      (lsu_wr_req),
        .lsu_req_i         (lsu_req),
        .lsu_ack_i         (lsu_ack),
        .wrb_rd_i          (wrb_rd_o),
        .wrb_wr_req_i      (wrb_wr_req),
        .fwd_lsu_rs1_o     (fwd_lsu_rs1),
        .fwd_lsu_rs2_o     (fwd_lsu_rs2),
        .fwd_wrb_rs1_o     (fwd_wrb_rs1),
        .fwd_wrb_rs2_o     (fwd_wrb_rs2),
        .if_id_exe_stall_o (if_id_exe_stall),
        .exe2lsu_flush_o   (exe2lsu_flush),
        .lsu_stall_o       (lsu_stall)
    );

endmodule : pipe_backend_top

`default_nettype wire

//--- verilog/pipe_pkg.sv
/*
 * Shared definitions for the integer pipeline back end.
 * Holds the decoded opcode encoding and the register index width.
 * Stage modules take these by importing the package inside their bodies.
 */
`default_nettype none

package pipe_pkg;

    // Register index width, 32 architectural registers with x0 tied to zero
    localparam int REG_ADDR_W = 5;

    // Decoded opcodes as they arrive on the issue port
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        // Immediate add, second operand is imm
        OP_ADDI = 3'd4,
        // Word load, address is rs1 + imm
        OP_LW   = 3'd5,
        // Word store, address is rs1 + imm and data is rs2
        OP_SW   = 3'd6
    } op_e;

endpackage : pipe_pkg

`default_nettype wire
